/* compile.f */
+incdir+src
src/lsu_pkg.sv
src/fetch_queue.sv
src/mem_op_table.sv
src/byte_access_engine.sv
src/byte_ram.sv
src/lsu_top.sv
dv/lsu_props.sv
dv/lsu_tb.sv

/* Makefile */
# Verilator build and run of the LSU testbench.

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
		--top-module lsu_tb -Mdir obj_dir -o lsu_sim

# An abnormal exit of the simulator also counts as a failure.
run: build
	./obj_dir/lsu_sim > sim.log 2>&1 || echo "tests failed" >> sim.log
	cat sim.log
	@if grep -q "tests failed" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f \
		--top-module lsu_tb

clean:
	rm -rf obj_dir sim.log

/* dv/lsu_tb.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam logic [1:0] K_STORE = 2'd0;
    localparam logic [1:0] K_LOAD  = 2'd1;
    localparam logic [1:0] K_FETCH = 2'd2;
    localparam int NSTEP   = 25;
    localparam int TIMEOUT = 400;
    localparam int AW      = $clog2(`LSU_RAM_BYTES);

    typedef struct packed {
        logic [1:0]           kind;
        mem_op_t              op;
        tag_t                 tag;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] data;
        logic [`LSU_XLEN-1:0] exp;
        logic                 batch; // Leave results pending for the next row.
        logic [3:0]           hold;  // Stall cycles once the operation is running.
    } step_t;

    logic                 clk;
    logic                 rst;
    tag_t                 dispatch_tag;
    mem_op_t              dispatch_op;
    logic [`LSU_XLEN-1:0] dispatch_addr;
    logic [`LSU_XLEN-1:0] dispatch_data;
    tag_t                 commit_tag;
    logic                 fetch_valid;
    logic [`LSU_XLEN-1:0] fetch_addr;
    logic                 stall;
    logic                 fetch_full;
    logic                 ins_ready;
    logic [`LSU_XLEN-1:0] ins_value;
    logic                 mem_done;
    tag_t                 mem_tag;
    logic [`LSU_XLEN-1:0] load_value;

    step_t       steps [NSTEP];
    logic [7:0]  model_mem [`LSU_RAM_BYTES];
    logic [31:0] exp_ins [$];
    tag_t        exp_tag [$];
    logic [31:0] exp_val [$];
    logic        exp_load [$];
    string       cur_test;

    lsu_top u_dut (.*);

    bind lsu_top lsu_props u_props (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_full  (fetch_full),
        .ins_ready   (ins_ready),
        .mem_done    (mem_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // Byte memory model
    // ----------------------------------------
    function automatic int size_of(mem_op_t op);
        case (op)
            OP_SW, OP_LW:         return 4;
            OP_SH, OP_LH, OP_LHU: return 2;
            default:              return 1;
        endcase
    endfunction

    function automatic void model_store(mem_op_t op, logic [31:0] addr, logic [31:0] data);
        logic [31:0] a;
        for (int i = 0; i < size_of(op); i++) begin
            a = addr + i;
            model_mem[a[AW-1:0]] = data[8*i +: 8]; // Lowest byte at the lowest address.
        end
    endfunction

    // Unsigned loads and LW keep the zero fill of w.
    function automatic logic [31:0] model_load(mem_op_t op, logic [31:0] addr);
        logic [31:0] a;
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < size_of(op); i++) begin
            a = addr + i;
            w[8*i +: 8] = model_mem[a[AW-1:0]];
        end
        if (op == OP_LB) w = {{24{w[7]}}, w[7:0]};
        if (op == OP_LH) w = {{16{w[15]}}, w[15:0]};
        return w;
    endfunction

    function automatic step_t make_step(logic [1:0] kind, mem_op_t op, tag_t tag,
                                        logic [31:0] addr, logic [31:0] data,
                                        logic batch, logic [3:0] hold);
        return '{kind, op, tag, addr, data, 32'h0, batch, hold};
    endfunction

    task automatic build_table();
        steps[0]  = make_step(K_STORE, OP_SW,  3'd1, 32'h040, $urandom(), 1'b0, 4'd0);
        steps[1]  = make_step(K_LOAD,  OP_LW,  3'd2, 32'h040, 32'h0, 1'b0, 4'd0);
        steps[2]  = make_step(K_STORE, OP_SW,  3'd3, 32'h100, $urandom(), 1'b0, 4'd0);
        steps[3]  = make_step(K_STORE, OP_SW,  3'd4, 32'h104, $urandom(), 1'b0, 4'd0);
        steps[4]  = make_step(K_STORE, OP_SB,  3'd5, 32'h101, 32'h85, 1'b0, 4'd0);
        steps[5]  = make_step(K_STORE, OP_SB,  3'd6, 32'h102, 32'h7a, 1'b0, 4'd0);
        steps[6]  = make_step(K_STORE, OP_SH,  3'd7, 32'h106, 32'h12349abc, 1'b0, 4'd0);
        steps[7]  = make_step(K_LOAD,  OP_LB,  3'd1, 32'h101, 32'h0, 1'b0, 4'd0);
        steps[8]  = make_step(K_LOAD,  OP_LBU, 3'd2, 32'h101, 32'h0, 1'b0, 4'd0);
        steps[9]  = make_step(K_LOAD,  OP_LH,  3'd3, 32'h106, 32'h0, 1'b0, 4'd0);
        steps[10] = make_step(K_LOAD,  OP_LHU, 3'd4, 32'h106, 32'h0, 1'b0, 4'd0);
        steps[11] = make_step(K_LOAD,  OP_LH,  3'd5, 32'h101, 32'h0, 1'b0, 4'd0);
        steps[12] = make_step(K_LOAD,  OP_LW,  3'd6, 32'h104, 32'h0, 1'b0, 4'd0);
        steps[13] = make_step(K_FETCH, OP_NONE, 3'd0, 32'h040, 32'h0, 1'b1, 4'd0);
        steps[14] = make_step(K_FETCH, OP_NONE, 3'd0, 32'h100, 32'h0, 1'b1, 4'd0);
        steps[15] = make_step(K_FETCH, OP_NONE, 3'd0, 32'h104, 32'h0, 1'b0, 4'd0);
        steps[16] = make_step(K_STORE, OP_SW,  3'd7, 32'h200, $urandom(), 1'b0, 4'd0);
        steps[17] = make_step(K_STORE, OP_SW,  3'd1, 32'h204, $urandom(), 1'b0, 4'd0);
        // Commits land while both fetches are still queued.
        steps[18] = make_step(K_FETCH, OP_NONE, 3'd0, 32'h200, 32'h0, 1'b1, 4'd0);
        steps[19] = make_step(K_FETCH, OP_NONE, 3'd0, 32'h204, 32'h0, 1'b1, 4'd0);
        steps[20] = make_step(K_STORE, OP_SW,  3'd2, 32'h300, $urandom(), 1'b1, 4'd0);
        steps[21] = make_step(K_LOAD,  OP_LW,  3'd3, 32'h300, 32'h0, 1'b1, 4'd0);
        steps[22] = make_step(K_LOAD,  OP_LB,  3'd4, 32'h102, 32'h0, 1'b0, 4'd0);
        steps[23] = make_step(K_STORE, OP_SW,  3'd5, 32'h080, $urandom(), 1'b0,
                              4'(1 + $urandom() % 12));
        steps[24] = make_step(K_LOAD,  OP_LW,  3'd6, 32'h080, 32'h0, 1'b0,
                              4'(1 + $urandom() % 12));
        for (int i = 0; i < NSTEP; i++) begin
            if (steps[i].kind == K_STORE) begin
                model_store(steps[i].op, steps[i].addr, steps[i].data);
            end else begin
                steps[i].exp = model_load(steps[i].kind == K_FETCH ? OP_LW : steps[i].op,
                                          steps[i].addr);
            end
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic stop_run(string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
            stop_run("a value did not match");
        end
    endtask

    task automatic check_strobes();
        tag_t        t;
        logic [31:0] v;
        logic        ld;
        if (mem_done) begin
            if (exp_tag.size() == 0) begin
                stop_run("mem_done pulsed with no operation outstanding");
            end else begin
                t  = exp_tag.pop_front();
                v  = exp_val.pop_front();
                ld = exp_load.pop_front();
                check("mem_tag", 32'(t), 32'(mem_tag));
                if (ld) check("load_value", v, load_value);
            end
        end
        if (ins_ready) begin
            if (exp_ins.size() == 0) begin
                stop_run("ins_ready pulsed with no fetch outstanding");
            end else begin
                v = exp_ins.pop_front();
                check("ins_value", v, ins_value);
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        check_strobes();
    endtask

    task automatic collect_results();
        int waited;
        waited = 0;
        while (exp_tag.size() != 0 || exp_ins.size() != 0) begin
            if (waited == TIMEOUT) begin
                stop_run("timed out waiting for mem_done or ins_ready");
            end else begin
                step_cycle();
                waited++;
            end
        end
        repeat (3) step_cycle(); // Catches a second completion.
    endtask

    task automatic hold_stall(int n);
        step_cycle();
        stall = 1'b1;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            if (mem_done || ins_ready) stop_run("a result was returned while stall was high");
        end
        stall = 1'b0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic apply_step(int i);
        step_t   s;
        mem_op_t op;
        s  = steps[i];
        op = s.op;
        cur_test = (s.kind == K_FETCH) ? $sformatf("step%0d_fetch", i)
                                       : $sformatf("step%0d_%s", i, op.name());
        step_cycle();
        if (s.kind == K_FETCH) begin
            fetch_valid = 1'b1;
            fetch_addr  = s.addr;
            exp_ins.push_back(s.exp);
            step_cycle();
            fetch_valid = 1'b0;
        end else begin
            dispatch_tag  = s.tag;
            dispatch_op   = s.op;
            dispatch_addr = s.addr;
            dispatch_data = s.data;
            exp_tag.push_back(s.tag);
            exp_val.push_back(s.exp);
            exp_load.push_back(s.kind == K_LOAD);
            step_cycle();
            dispatch_op = OP_NONE;
            commit_tag  = s.tag;
            step_cycle();
            commit_tag  = '0;
        end
        if (s.hold != 0) hold_stall(int'(s.hold));
        if (!s.batch) collect_results();
    endtask

    // Seven pushes against a stalled engine fill the queue.
    task automatic fill_fetch_queue();
        logic [31:0] fill_addr [7];
        fill_addr = '{32'h040, 32'h100, 32'h104, 32'h200, 32'h204, 32'h300, 32'h080};
        cur_test  = "fetch_queue_full";
        step_cycle();
        stall = 1'b1;
        for (int k = 0; k < 7; k++) begin
            fetch_valid = 1'b1;
            fetch_addr  = fill_addr[k];
            exp_ins.push_back(model_load(OP_LW, fill_addr[k]));
            step_cycle();
        end
        fetch_valid = 1'b0;
        check("fetch_full", 32'd1, 32'(fetch_full));
        stall = 1'b0;
        collect_results();
        check("fetch_full", 32'd0, 32'(fetch_full));
    endtask

    initial begin
        void'($urandom(96643));
        rst           = 1'b0;
        dispatch_tag  = '0;
        dispatch_op   = OP_NONE;
        dispatch_addr = '0;
        dispatch_data = '0;
        commit_tag    = '0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        stall         = 1'b0;
        cur_test      = "reset";
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check("fetch_full", 32'd0, 32'(fetch_full));
        check("mem_done", 32'd0, 32'(mem_done));
        check("ins_ready", 32'd0, 32'(ins_ready));
        for (int i = 0; i < NSTEP; i++) apply_step(i);
        fill_fetch_queue();
        $display("all tests passed");
        $finish;
    end

endmodule

/* dv/lsu_props.sv */
`timescale 1ns/100ps

module lsu_props (
    input logic clk,
    input logic rst,
    input logic fetch_valid,
    input logic fetch_full,
    input logic ins_ready,
    input logic mem_done
);

    // ----------------------------------------
    // Fetch side
    // ----------------------------------------
    // The fetch source must stop pushing while the queue reports full.
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst) !(fetch_valid && fetch_full)
    ) else $error("fetch pushed while fetch_full was high");

    // ----------------------------------------
    // Result strobes
    // ----------------------------------------
    one_strobe_per_cycle: assert property (
        @(posedge clk) disable iff (!rst) !(ins_ready && mem_done)
    ) else $error("ins_ready and mem_done high in the same cycle");

    // A memory operation completes once.
    mem_done_pulse: assert property (
        @(posedge clk) disable iff (!rst) mem_done |=> !mem_done
    ) else $error("mem_done high in two consecutive cycles");

endmodule

/* src/lsu_top.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  tag_t                 dispatch_tag,
    input  mem_op_t              dispatch_op,
    input  logic [`LSU_XLEN-1:0] dispatch_addr,
    input  logic [`LSU_XLEN-1:0] dispatch_data,
    input  tag_t                 commit_tag,
    input  logic                 fetch_valid,
    input  logic [`LSU_XLEN-1:0] fetch_addr,
    input  logic                 stall,
    output logic                 fetch_full,
    output logic                 ins_ready,
    output logic [`LSU_XLEN-1:0] ins_value,
    output logic                 mem_done,
    output tag_t                 mem_tag,
    output logic [`LSU_XLEN-1:0] load_value
);

    logic                 head_valid;
    logic [`LSU_XLEN-1:0] head_addr;
    logic                 pop;
    logic                 sel_valid;
    tag_t                 sel_tag;
    mem_op_t              sel_op;
    logic [`LSU_XLEN-1:0] sel_addr;
    logic [`LSU_XLEN-1:0] sel_data;
    logic                 retire;
    logic [`LSU_XLEN-1:0] ram_addr;
    logic                 ram_we;
    logic [7:0]           ram_wdata;
    logic [7:0]           ram_rdata;

    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (fetch_valid),
        .push_addr  (fetch_addr),
        .pop        (pop),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .full       (fetch_full)
    );

    mem_op_table u_mem_op_table (
        .clk           (clk),
        .rst           (rst),
        .dispatch_tag  (dispatch_tag),
        .dispatch_op   (dispatch_op),
        .dispatch_addr (dispatch_addr),
        .dispatch_data (dispatch_data),
        .commit_tag    (commit_tag),
        .retire        (retire),
        .sel_valid     (sel_valid),
        .sel_tag       (sel_tag),
        .sel_op        (sel_op),
        .sel_addr      (sel_addr),
        .sel_data      (sel_data)
    );

    // Committed operations go before fetches.
    byte_access_engine u_engine (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .sel_valid  (sel_valid),
        .sel_tag    (sel_tag),
        .sel_op     (sel_op),
        .sel_addr   (sel_addr),
        .sel_data   (sel_data),
        .retire     (retire),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .pop        (pop),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .ins_ready  (ins_ready),
        .ins_value  (ins_value),
        .mem_done   (mem_done),
        .mem_tag    (mem_tag),
        .load_value (load_value)
    );

    byte_ram u_byte_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

/* src/byte_ram.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module byte_ram (
    input  logic                 clk,
    input  logic [`LSU_XLEN-1:0] ram_addr,
    input  logic                 ram_we,
    input  logic [7:0]           ram_wdata,
    output logic [7:0]           ram_rdata
);

    localparam int AW = $clog2(`LSU_RAM_BYTES);

    logic [7:0]    mem [`LSU_RAM_BYTES];
    logic [AW-1:0] idx;

    // Upper address bits wrap onto the array.
    assign idx = ram_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (ram_we) mem[idx] <= ram_wdata;
        ram_rdata <= mem[idx]; // Old byte on a same-cycle write.
    end

endmodule

/* src/byte_access_engine.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module byte_access_engine import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 sel_valid,
    input  tag_t                 sel_tag,
    input  mem_op_t              sel_op,
    input  logic [`LSU_XLEN-1:0] sel_addr,
    input  logic [`LSU_XLEN-1:0] sel_data,
    output logic                 retire,
    input  logic                 head_valid,
    input  logic [`LSU_XLEN-1:0] head_addr,
    output logic                 pop,
    output logic [`LSU_XLEN-1:0] ram_addr,
    output logic                 ram_we,
    output logic [7:0]           ram_wdata,
    input  logic [7:0]           ram_rdata,
    output logic                 ins_ready,
    output logic [`LSU_XLEN-1:0] ins_value,
    output logic                 mem_done,
    output tag_t                 mem_tag,
    output logic [`LSU_XLEN-1:0] load_value
);

    logic                 busy;
    logic                 is_fetch;
    logic                 is_store;
    mem_op_t              cur_op;
    tag_t                 cur_tag;
    logic [`LSU_XLEN-1:0] base;
    logic [`LSU_XLEN-1:0] word;
    logic [`LSU_XLEN-1:0] word_next;
    logic [1:0]           last_off;
    logic [1:0]           off;      // Byte offset on the RAM bus.
    logic                 off_vld;
    logic [1:0]           lag_off;  // Offset the RAM is answering now.
    logic                 lag_vld;
    logic                 start;
    logic                 rd_last;
    logic                 wr_last;

    // Wait one cycle after a retire or pop so the source can drop the entry.
    assign start = !busy && !stall && !retire && !pop && (sel_valid || head_valid);

    assign rd_last = busy && !is_store && !off_vld && lag_vld && (lag_off == last_off);
    assign wr_last = busy && is_store && off_vld && (off == last_off);

    // ----------------------------------------
    // RAM bus
    // ----------------------------------------
    assign ram_addr  = base + `LSU_XLEN'(off);
    assign ram_we    = busy && is_store && off_vld && !stall;
    assign ram_wdata = word[{off, 3'b000} +: 8];

    always_comb begin
        word_next = word;
        if (lag_vld) word_next[{lag_off, 3'b000} +: 8] = ram_rdata;
    end

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= 1'b0;
            off_vld   <= 1'b0;
            lag_vld   <= 1'b0;
            retire    <= 1'b0;
            pop       <= 1'b0;
            ins_ready <= 1'b0;
            mem_done  <= 1'b0;
        end else begin
            retire    <= 1'b0;
            pop       <= 1'b0;
            ins_ready <= 1'b0;
            mem_done  <= 1'b0;
            // Tracks the bus, and keeps the last byte valid through a stall.
            lag_vld   <= busy && !is_store && (off_vld || (stall && lag_vld));
            if (start) begin
                busy    <= 1'b1;
                off_vld <= 1'b1;
            end else if (busy && !stall) begin
                if (off_vld && off == last_off) off_vld <= 1'b0;
                if (wr_last) begin
                    busy     <= 1'b0;
                    mem_done <= 1'b1;
                    retire   <= 1'b1;
                end
                if (rd_last) begin
                    busy <= 1'b0;
                    if (is_fetch) begin
                        ins_ready <= 1'b1;
                        pop       <= 1'b1;
                    end else begin
                        mem_done <= 1'b1;
                        retire   <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lag_off <= off;
        if (start) begin
            off <= 2'd0;
            if (sel_valid) begin
                is_fetch <= 1'b0;
                is_store <= op_is_store(sel_op);
                cur_op   <= sel_op;
                cur_tag  <= sel_tag;
                base     <= sel_addr;
                word     <= sel_data;
                last_off <= 2'(op_bytes(sel_op) - 3'd1);
            end else begin
                is_fetch <= 1'b1;
                is_store <= 1'b0;
                cur_op   <= OP_NONE;
                cur_tag  <= '0;
                base     <= head_addr;
                word     <= '0;
                last_off <= 2'd3;
            end
        end else if (busy) begin
            // The bus address is held in a stall, so a byte that arrives then is still good.
            if (!is_store) word <= word_next;
            if (!stall && off_vld && off != last_off) off <= off + 2'd1;
        end
        if (!stall && (rd_last || wr_last)) begin
            mem_tag <= cur_tag;
        end
        if (!stall && rd_last) begin
            ins_value  <= word_next;
            load_value <= op_extend(cur_op, word_next);
        end
    end

endmodule

/* src/mem_op_table.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module mem_op_table import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  tag_t                 dispatch_tag,
    input  mem_op_t              dispatch_op,
    input  logic [`LSU_XLEN-1:0] dispatch_addr,
    input  logic [`LSU_XLEN-1:0] dispatch_data,
    input  tag_t                 commit_tag,
    input  logic                 retire,
    output logic                 sel_valid,
    output tag_t                 sel_tag,
    output mem_op_t              sel_op,
    output logic [`LSU_XLEN-1:0] sel_addr,
    output logic [`LSU_XLEN-1:0] sel_data
);

    mem_op_t              ent_op   [`LSU_TAGS];
    logic [`LSU_XLEN-1:0] ent_addr [`LSU_TAGS];
    logic [`LSU_XLEN-1:0] ent_data [`LSU_TAGS];
    logic [`LSU_TAGS-1:0] busy;
    logic [`LSU_TAGS-1:0] committed;
    tag_t                 hold_tag;
    tag_t                 low_tag;
    logic                 dispatch_en;

    assign dispatch_en = (dispatch_op != OP_NONE) && (dispatch_tag != '0);

    // ----------------------------------------
    // Selection
    // ----------------------------------------
    always_comb begin
        low_tag = '0;
        for (int i = `LSU_TAGS - 1; i > 0; i--) begin
            if (committed[i]) low_tag = tag_t'(i);
        end
    end

    // An entry stays selected until it retires.
    assign sel_tag   = committed[hold_tag] ? hold_tag : low_tag;
    assign sel_valid = (sel_tag != '0); // Slot 0 is never committed.
    assign sel_op    = sel_valid ? ent_op[sel_tag] : OP_NONE;
    assign sel_addr  = ent_addr[sel_tag];
    assign sel_data  = ent_data[sel_tag];

    // ----------------------------------------
    // Entry flags
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= '0;
            committed <= '0;
            hold_tag  <= '0;
        end else begin
            hold_tag <= sel_tag;
            if (retire && sel_valid) begin
                busy[sel_tag]      <= 1'b0;
                committed[sel_tag] <= 1'b0;
            end
            if (dispatch_en) begin
                busy[dispatch_tag]      <= 1'b1;
                committed[dispatch_tag] <= 1'b0;
            end
            if (commit_tag != '0 && busy[commit_tag]) begin
                committed[commit_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_en) begin
            ent_op[dispatch_tag]   <= dispatch_op;
            ent_addr[dispatch_tag] <= dispatch_addr;
            ent_data[dispatch_tag] <= dispatch_data;
        end
    end

endmodule

/* src/fetch_queue.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module fetch_queue #(
    parameter int DEPTH = `LSU_FQ_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  logic [`LSU_XLEN-1:0] push_addr,
    input  logic                 pop,
    output logic                 head_valid,
    output logic [`LSU_XLEN-1:0] head_addr,
    output logic                 full
);

    localparam int PW = $clog2(DEPTH);

    logic [`LSU_XLEN-1:0] slots [DEPTH];
    logic [PW-1:0]        head;
    logic [PW-1:0]        tail;
    logic [PW:0]          count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push && (count != (PW+1)'(DEPTH));
    assign do_pop  = pop && head_valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == PW'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == PW'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) slots[tail] <= push_addr;
    end

    assign head_valid = (count != '0);
    assign head_addr  = slots[head];

    // One slot stays spare for an address already on its way in.
    assign full = (count >= (PW+1)'(DEPTH - 1));

endmodule

/* src/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

    typedef enum logic [4:0] {
        OP_LB   = 5'b10010,
        OP_LH   = 5'b10011,
        OP_LW   = 5'b10100,
        OP_LBU  = 5'b10101,
        OP_LHU  = 5'b10110,
        OP_SB   = 5'b10111,
        OP_SH   = 5'b11000,
        OP_SW   = 5'b11001,
        OP_NONE = 5'b11111
    } mem_op_t;

    typedef logic [$clog2(`LSU_TAGS)-1:0] tag_t;

    // Bytes moved by one operation.
    function automatic logic [2:0] op_bytes(mem_op_t op);
        case (op)
            OP_LW, OP_SW:         return 3'd4;
            OP_LH, OP_LHU, OP_SH: return 3'd2;
            default:              return 3'd1;
        endcase
    endfunction

    function automatic logic op_is_store(mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // Sign or zero extension of an assembled little-endian word.
    function automatic logic [`LSU_XLEN-1:0] op_extend(mem_op_t op,
                                                       logic [`LSU_XLEN-1:0] word);
        case (op)
            OP_LB:   return {{(`LSU_XLEN-8){word[7]}}, word[7:0]};
            OP_LBU:  return {{(`LSU_XLEN-8){1'b0}}, word[7:0]};
            OP_LH:   return {{(`LSU_XLEN-16){word[15]}}, word[15:0]};
            OP_LHU:  return {{(`LSU_XLEN-16){1'b0}}, word[15:0]};
            default: return word;
        endcase
    endfunction

endpackage

/* src/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data and address width.
`define LSU_XLEN 32

// Reorder-buffer tags, tag 0 means no operation.
`define LSU_TAGS 8

// Fetch queue entries. Full is reported one entry early.
`define LSU_FQ_DEPTH 8

`define LSU_RAM_BYTES 1024

`endif
